// File: panoTop_defines.svh
`ifndef PANOTOP_DEFINES_SVH
`define PANOTOP_DEFINES_SVH

////////////////////
// SPI flash link
////////////////////

// clkOsc cycles per SCK half-period
`define SPI_CLK_DIV 2

// Flash address of the first command word
`define BOOT_ADDR 24'h010000

////////////////////
// LED output
////////////////////

// PWM counter and colour channel resolution
`define PWM_BITS 8

`endif

// File: spiFlashPkg.sv
package spiFlashPkg;

    // Standard slow read, no dummy cycles
    localparam logic [7:0] FLASH_READ = 8'h03;

    // Reader FSM
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR,
        DATA,
        DONE
    } readerState_e;

endpackage

// File: ledSeqPkg.sv
`include "panoTop_defines.svh"

package ledSeqPkg;

    ////////////////////
    // Command tags
    ////////////////////

    localparam logic [7:0] TAG_COLOR = 8'h01;
    localparam logic [7:0] TAG_WAIT  = 8'h02;
    localparam logic [7:0] TAG_HALT  = 8'hFF;

    ////////////////////
    // Command word
    ////////////////////

    typedef struct packed {
        logic [7:0]           tag;
        logic [`PWM_BITS-1:0] red;
        logic [`PWM_BITS-1:0] green;
        logic [`PWM_BITS-1:0] blue;
    } seqColor_t;

    typedef struct packed {
        logic [7:0]  tag;
        logic [23:0] count;
    } seqWait_t;

    // Tag in the top byte for both views, first byte out of the flash
    typedef union packed {
        seqColor_t color;
        seqWait_t  waitCmd;
    } seqWord_u;

    typedef struct packed {
        logic [`PWM_BITS-1:0] red;
        logic [`PWM_BITS-1:0] green;
        logic [`PWM_BITS-1:0] blue;
    } rgb_t;

endpackage

// File: spiFlashReader.sv
`include "panoTop_defines.svh"

module spiFlashReader
    import spiFlashPkg::*;
(
    input  logic       clkOsc,
    input  logic       arstN,
    input  logic       hold,
    input  logic       halt,
    input  logic       spiMiso,
    output logic       spiCsN,
    output logic       spiSck,
    output logic       spiMosi,
    output logic       byteValid,
    output logic [7:0] byteData
);

    localparam int DivW = ($clog2(`SPI_CLK_DIV) > 0) ? $clog2(`SPI_CLK_DIV) : 1;
    localparam logic [DivW-1:0] DivLast = DivW'(`SPI_CLK_DIV - 1);

    readerState_e    state;
    logic [DivW-1:0] divCnt;
    logic [4:0]      bitCnt;
    logic [31:0]     txShift;
    logic [6:0]      rxShift;
    logic            divDone;
    logic            byteStart;
    logic            shifting;
    logic            sckRise;
    logic            sckFall;

    assign divDone = (divCnt == DivLast);

    // First cycle of a data byte, SCK still low
    assign byteStart = (state == DATA) && (bitCnt == 5'd0) && !spiSck && (divCnt == '0);

    // Stall only at a byte boundary
    assign shifting = (state == CMD) || (state == ADDR) ||
                      ((state == DATA) && !(byteStart && (hold || halt)));

    assign sckRise = shifting && divDone && !spiSck;
    assign sckFall = shifting && divDone && spiSck;

    ////////////////////
    // Control FSM
    ////////////////////

    always_ff @(posedge clkOsc or negedge arstN) begin
        if (!arstN) begin
            state     <= IDLE;
            spiCsN    <= 1'b1;
            spiSck    <= 1'b0;
            spiMosi   <= 1'b0;
            divCnt    <= '0;
            bitCnt    <= 5'd0;
            byteValid <= 1'b0;
        end else begin
            byteValid <= 1'b0;
            case (state)
                IDLE: begin
                    spiCsN  <= 1'b0;
                    spiMosi <= FLASH_READ[7];
                    state   <= CMD;
                end
                DONE: begin
                    spiCsN <= 1'b1;
                end
                default: begin
                    if (byteStart && halt) begin
                        state  <= DONE;
                        spiCsN <= 1'b1;
                    end else if (shifting) begin
                        divCnt <= divDone ? '0 : divCnt + DivW'(1);
                        if (sckRise) begin
                            spiSck <= 1'b1;
                            if (state == DATA && bitCnt == 5'd7) begin
                                byteValid <= 1'b1;
                            end
                        end
                        if (sckFall) begin
                            spiSck  <= 1'b0;
                            spiMosi <= txShift[31];
                            // Command and address share one 32-bit count
                            if (state == CMD && bitCnt == 5'd7) begin
                                state <= ADDR;
                            end
                            if (state == ADDR && bitCnt == 5'd31) begin
                                state <= DATA;
                            end
                            if (state == DATA && bitCnt == 5'd7) begin
                                bitCnt <= 5'd0;
                            end else begin
                                bitCnt <= bitCnt + 5'd1;
                            end
                        end
                    end
                end
            endcase
        end
    end

    ////////////////////
    // Shift registers
    ////////////////////

    always_ff @(posedge clkOsc) begin
        if (state == IDLE) begin
            // Bit 7 of the opcode is already on MOSI
            txShift <= {FLASH_READ[6:0], `BOOT_ADDR, 1'b0};
        end else if (sckFall) begin
            txShift <= {txShift[30:0], 1'b0};
        end
        if (sckRise && state == DATA) begin
            rxShift <= {rxShift[5:0], spiMiso};
            if (bitCnt == 5'd7) begin
                byteData <= {rxShift, spiMiso};
            end
        end
    end

endmodule

// File: wordAssembler.sv
module wordAssembler
    import ledSeqPkg::*;
(
    input  logic       clkOsc,
    input  logic       arstN,
    input  logic       byteValid,
    input  logic [7:0] byteData,
    output logic       wordValid,
    output seqWord_u   word
);

    logic [23:0] upperBytes;
    logic [1:0]  byteCnt;

    // Fourth byte completes the word in the same cycle
    assign wordValid = byteValid && (byteCnt == 2'd3);
    assign word      = seqWord_u'({upperBytes, byteData});

    always_ff @(posedge clkOsc or negedge arstN) begin
        if (!arstN) begin
            byteCnt <= 2'd0;
        end else if (byteValid) begin
            byteCnt <= byteCnt + 2'd1;
        end
    end

    // First byte ends up in the top byte
    always_ff @(posedge clkOsc) begin
        if (byteValid) begin
            upperBytes <= {upperBytes[15:0], byteData};
        end
    end

endmodule

// File: ledSequencer.sv
module ledSequencer
    import ledSeqPkg::*;
(
    input  logic     clkOsc,
    input  logic     arstN,
    input  logic     wordValid,
    input  seqWord_u word,
    output logic     hold,
    output logic     halt,
    output logic     halted,
    output rgb_t     color
);

    logic [23:0] waitCnt;
    logic        haltReg;

    // High for exactly count cycles after the wait word
    assign hold = (waitCnt != 24'd0);

    assign halt   = haltReg;
    assign halted = haltReg;

    ////////////////////
    // Command execute
    ////////////////////

    always_ff @(posedge clkOsc or negedge arstN) begin
        if (!arstN) begin
            color   <= '0;
            waitCnt <= 24'd0;
            haltReg <= 1'b0;
        end else begin
            if (hold) begin
                waitCnt <= waitCnt - 24'd1;
            end
            if (wordValid) begin
                // Tag byte is common to both views
                case (word.color.tag)
                    TAG_COLOR: begin
                        color.red   <= word.color.red;
                        color.green <= word.color.green;
                        color.blue  <= word.color.blue;
                    end
                    TAG_WAIT: begin
                        waitCnt <= word.waitCmd.count;
                    end
                    TAG_HALT: begin
                        haltReg <= 1'b1;
                    end
                    default: begin
                        // Unknown tag is a no-op
                    end
                endcase
            end
        end
    end

endmodule

// File: ledPwm.sv
`include "panoTop_defines.svh"

module ledPwm
    import ledSeqPkg::*;
(
    input  logic clkOsc,
    input  logic arstN,
    input  rgb_t color,
    output logic ledRed,
    output logic ledGreen,
    output logic ledBlue
);

    logic [`PWM_BITS-1:0] pwmCnt;

    // Free running, value d gives d high cycles per period
    always_ff @(posedge clkOsc or negedge arstN) begin
        if (!arstN) begin
            pwmCnt   <= '0;
            ledRed   <= 1'b0;
            ledGreen <= 1'b0;
            ledBlue  <= 1'b0;
        end else begin
            pwmCnt   <= pwmCnt + 1'b1;
            ledRed   <= (pwmCnt < color.red);
            ledGreen <= (pwmCnt < color.green);
            ledBlue  <= (pwmCnt < color.blue);
        end
    end

endmodule

// File: panoTop.sv
module panoTop
    import ledSeqPkg::*;
(
    input  logic clkOsc,
    input  logic arstN,
    input  logic spiMiso,
    output logic spiCsN,
    output logic spiSck,
    output logic spiMosi,
    output logic ledRed,
    output logic ledGreen,
    output logic ledBlue,
    output logic halted
);

    logic       byteValid;
    logic [7:0] byteData;
    logic       wordValid;
    seqWord_u   word;
    logic       hold;
    logic       halt;
    rgb_t       color;

    ////////////////////
    // Flash to LEDs
    ////////////////////

    spiFlashReader u_spiFlashReader (
        .clkOsc    (clkOsc),
        .arstN     (arstN),
        .hold      (hold),
        .halt      (halt),
        .spiMiso   (spiMiso),
        .spiCsN    (spiCsN),
        .spiSck    (spiSck),
        .spiMosi   (spiMosi),
        .byteValid (byteValid),
        .byteData  (byteData)
    );

    wordAssembler u_wordAssembler (
        .clkOsc    (clkOsc),
        .arstN     (arstN),
        .byteValid (byteValid),
        .byteData  (byteData),
        .wordValid (wordValid),
        .word      (word)
    );

    // Hold and halt go back up to the reader
    ledSequencer u_ledSequencer (
        .clkOsc    (clkOsc),
        .arstN     (arstN),
        .wordValid (wordValid),
        .word      (word),
        .hold      (hold),
        .halt      (halt),
        .halted    (halted),
        .color     (color)
    );

    ledPwm u_ledPwm (
        .clkOsc   (clkOsc),
        .arstN    (arstN),
        .color    (color),
        .ledRed   (ledRed),
        .ledGreen (ledGreen),
        .ledBlue  (ledBlue)
    );

endmodule

// File: spiFlashModel.sv
`include "panoTop_defines.svh"

module spiFlashModel (
    input  logic clkOsc,
    input  logic spiCsN,
    input  logic spiSck,
    input  logic spiMosi,
    output logic spiMiso
);

    // Slow read opcode the flash accepts
    localparam logic [7:0] ReadOpcode = 8'h03;

    // Entry 0 is the byte at the boot address
    logic [7:0]  mem [0:255];
    logic        sckLast;
    int          bitCnt;
    int          dataBit;
    logic [31:0] shiftIn;
    logic [7:0]  opcode;
    logic [23:0] addr;
    logic        opcodeBad;
    logic        addrBad;

    assign dataBit = bitCnt - 32;

    initial begin
        spiMiso   = 1'b0;
        sckLast   = 1'b0;
        bitCnt    = 0;
        opcodeBad = 1'b0;
        addrBad   = 1'b0;
    end

    // SCK sampled on the falling clock edge away from the DUT edge
    always @(negedge clkOsc) begin
        sckLast <= spiSck;
        if (spiCsN) begin
            bitCnt  <= 0;
            spiMiso <= 1'b0;
        end else if (spiSck && !sckLast) begin
            bitCnt <= bitCnt + 1;
            if (bitCnt < 32) begin
                shiftIn <= {shiftIn[30:0], spiMosi};
            end
            if (bitCnt == 7) begin
                opcode    <= {shiftIn[6:0], spiMosi};
                opcodeBad <= ({shiftIn[6:0], spiMosi} != ReadOpcode);
            end
            if (bitCnt == 31) begin
                addr    <= {shiftIn[22:0], spiMosi};
                addrBad <= ({shiftIn[22:0], spiMosi} != `BOOT_ADDR);
            end
        end else if (!spiSck && sckLast && bitCnt >= 32) begin
            // Next data bit goes out MSB first after falling SCK
            spiMiso <= mem[dataBit[10:3]][3'd7 - dataBit[2:0]];
        end
    end

endmodule

// File: panoTop_assert.sv
module panoTop_assert
    import spiFlashPkg::*;
(
    input logic         clkOsc,
    input logic         arstN,
    input logic         spiCsN,
    input logic         spiSck,
    input logic         hold,
    input logic         halt,
    input readerState_e state
);

    int failCount = 0;

    ////////////////////
    // SPI pins
    ////////////////////

    // SCK parked low while the flash is deselected
    property sckQuiet;
        @(posedge clkOsc) disable iff (!arstN)
            spiCsN |-> !spiSck && $stable(spiSck);
    endproperty

    ////////////////////
    // Hold and halt
    ////////////////////

    // Waits only start once data is streaming
    property holdInWait;
        @(posedge clkOsc) disable iff (!arstN)
            $rose(hold) |-> (state == DATA) && !halt;
    endproperty

    property doneSticks;
        @(posedge clkOsc) disable iff (!arstN)
            (state == DONE) |=> (state == DONE);
    endproperty

    assert property (sckQuiet)
    else begin
        failCount++;
        $error("SCK moved while chip select was high");
    end

    assert property (holdInWait)
    else begin
        failCount++;
        $error("hold rose outside the data phase or after halt");
    end

    assert property (doneSticks)
    else begin
        failCount++;
        $error("reader left the DONE state");
    end

endmodule

// File: tb_panoTop.sv
`include "panoTop_defines.svh"

module tb_panoTop
    import ledSeqPkg::*;
();

    logic     clkOsc;
    logic     arstN;
    logic     spiMiso;
    logic     spiCsN;
    logic     spiSck;
    logic     spiMosi;
    logic     ledRed;
    logic     ledGreen;
    logic     ledBlue;
    logic     halted;

    seqWord_u prog[$];
    int       waitIdx[$];
    int       waitSum;
    integer   seed;
    int       cycles;
    int       cycleLimit;
    int       errors;
    int       errorsAtStart;
    int       testsRun;
    int       testsFailed;

    panoTop u_panoTop (
        .clkOsc   (clkOsc),
        .arstN    (arstN),
        .spiMiso  (spiMiso),
        .spiCsN   (spiCsN),
        .spiSck   (spiSck),
        .spiMosi  (spiMosi),
        .ledRed   (ledRed),
        .ledGreen (ledGreen),
        .ledBlue  (ledBlue),
        .halted   (halted)
    );

    spiFlashModel u_flash (
        .clkOsc  (clkOsc),
        .spiCsN  (spiCsN),
        .spiSck  (spiSck),
        .spiMosi (spiMosi),
        .spiMiso (spiMiso)
    );

    bind spiFlashReader panoTop_assert u_readerAssert (
        .clkOsc (clkOsc),
        .arstN  (arstN),
        .spiCsN (spiCsN),
        .spiSck (spiSck),
        .hold   (hold),
        .halt   (halt),
        .state  (state)
    );

    always #4 clkOsc = ~clkOsc;

    always @(posedge clkOsc) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////
    // Program
    ////////////////////

    // Six colour and wait pairs, unknown tag and zero wait after the third colour
    task automatic buildProgram();
        seqWord_u    w;
        logic [31:0] r;
        for (int k = 0; k < 6; k++) begin
            r = $random(seed);
            w = seqWord_u'({TAG_COLOR, r[23:0]});
            prog.push_back(w);
            if (k == 2) begin
                r = $random(seed);
                prog.push_back(seqWord_u'({8'h5C, r[23:0]}));
                prog.push_back(seqWord_u'({TAG_WAIT, 24'd0}));
            end
            r = $random(seed);
            w.waitCmd.tag   = TAG_WAIT;
            w.waitCmd.count = 24'(600 + (r[15:0] % 301));
            waitIdx.push_back(prog.size());
            prog.push_back(w);
            waitSum = waitSum + int'(w.waitCmd.count);
        end
        prog.push_back(seqWord_u'({TAG_HALT, 24'd0}));
    endtask

    task automatic loadFlash();
        logic [31:0] bits;
        for (int i = 0; i < prog.size(); i++) begin
            bits = prog[i];
            for (int b = 0; b < 4; b++) begin
                u_flash.mem[4 * i + b] = bits[31 - 8 * b -: 8];
            end
        end
    endtask

    // Colour in effect once words 0 to lastWord have run
    function automatic rgb_t expectColors(input int lastWord);
        rgb_t     c;
        seqWord_u w;
        c = '0;
        for (int i = 0; i <= lastWord; i++) begin
            w = prog[i];
            if (w.color.tag == TAG_HALT) begin
                break;
            end
            if (w.color.tag == TAG_COLOR) begin
                c.red   = w.color.red;
                c.green = w.color.green;
                c.blue  = w.color.blue;
            end
        end
        return c;
    endfunction

    ////////////////////
    // Helpers
    ////////////////////

    task automatic waitBits(input int target);
        while (u_flash.bitCnt < target) begin
            @(negedge clkOsc);
        end
    endtask

    // One full PWM period
    task automatic measureDuty(output rgb_t duty);
        int r;
        int g;
        int b;
        r = 0;
        g = 0;
        b = 0;
        repeat (256) begin
            @(negedge clkOsc);
            r = r + int'(ledRed);
            g = g + int'(ledGreen);
            b = b + int'(ledBlue);
        end
        duty.red   = 8'(r);
        duty.green = 8'(g);
        duty.blue  = 8'(b);
    endtask

    task automatic checkColor(input string name, input rgb_t expected, input rgb_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected r=%0d g=%0d b=%0d actual r=%0d g=%0d b=%0d", name,
                     expected.red, expected.green, expected.blue,
                     actual.red, actual.green, actual.blue);
            errors++;
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic startTest();
        errorsAtStart = errors;
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errors > errorsAtStart) begin
            testsFailed++;
            $display("Test %s: failed", name);
        end else begin
            $display("Test %s: passed", name);
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        rgb_t  duty;
        string name;
        logic  sckMoved;
        logic  csDropped;
        logic  sckLast;
        clkOsc      = 1'b0;
        arstN       = 1'b0;
        seed        = 32'hf3ee6b50;
        waitSum     = 0;
        cycles      = 0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        buildProgram();
        loadFlash();
        cycleLimit = (32 + 32 * prog.size()) * 2 * `SPI_CLK_DIV + waitSum + 2000;

        repeat (2) @(negedge clkOsc);
        startTest();
        checkBit("reset spiCsN", 1'b1, spiCsN);
        checkBit("reset ledRed", 1'b0, ledRed);
        checkBit("reset ledGreen", 1'b0, ledGreen);
        checkBit("reset ledBlue", 1'b0, ledBlue);
        finishTest("reset outputs");
        arstN = 1'b1;

        startTest();
        waitBits(32);
        if (u_flash.opcodeBad) begin
            $display("Error: flash header: flash saw opcode %h instead of the read opcode",
                     u_flash.opcode);
            errors++;
        end
        if (u_flash.addrBad) begin
            $display("Error: flash header: flash saw address %h instead of the boot address",
                     u_flash.addr);
            errors++;
        end
        finishTest("flash header");

        // Measure well inside each long wait
        for (int k = 0; k < waitIdx.size(); k++) begin
            startTest();
            name = (k == 2) ? "duty after unknown tag and zero wait" :
                              $sformatf("duty in wait %0d", k);
            waitBits(32 + 32 * (waitIdx[k] + 1));
            repeat (300) @(negedge clkOsc);
            measureDuty(duty);
            checkColor(name, expectColors(waitIdx[k]), duty);
            checkBit($sformatf("halted in wait %0d", k), 1'b0, halted);
            finishTest(name);
        end

        startTest();
        while (!halted) begin
            @(negedge clkOsc);
        end
        while (!spiCsN) begin
            @(negedge clkOsc);
        end
        sckMoved  = 1'b0;
        csDropped = 1'b0;
        sckLast   = spiSck;
        repeat (100) begin
            @(negedge clkOsc);
            if (spiSck !== sckLast) begin
                sckMoved = 1'b1;
            end
            if (spiCsN !== 1'b1) begin
                csDropped = 1'b1;
            end
        end
        checkBit("SCK edge after halt", 1'b0, sckMoved);
        checkBit("spiCsN low after halt", 1'b0, csDropped);
        measureDuty(duty);
        checkColor("duty after halt", expectColors(prog.size() - 1), duty);
        checkBit("halted", 1'b1, halted);
        finishTest("halt");

        errors = errors + u_panoTop.u_spiFlashReader.u_readerAssert.failCount;
        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0 && testsFailed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: panoTop.f
+incdir+.
spiFlashPkg.sv
ledSeqPkg.sv
spiFlashReader.sv
wordAssembler.sv
ledSequencer.sv
ledPwm.sv
panoTop.sv
spiFlashModel.sv
panoTop_assert.sv
tb_panoTop.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_panoTop -f panoTop.f

out=$(./obj_dir/Vtb_panoTop +verilator+error+limit+100 || true)
echo "$out"

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
